/* sources.f */
rtl/mulPkg.sv
rtl/operandCapture.sv
rtl/baughWooleyArray.sv
rtl/carrySelectAdder.sv
rtl/arrayMultiplier.sv
verif/tbArrayMultiplier.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = tbArrayMultiplier
FILELIST = sources.f
BUILD    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)

# the simulation output is kept in a shell variable and searched for the pass line
run: compile
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "All tests passed"

clean:
	rm -rf $(BUILD)

/* verif/tbArrayMultiplier.sv */
`timescale 1ns/1ns
`default_nettype none

module tbArrayMultiplier;
	import mulPkg::*;

	localparam int resetCycles = 2;
	localparam int resetIdleCycles = 4;
	localparam int randomCount = 500;
	localparam int cornerCount = 7;
	localparam int backToBackCount = 20;
	localparam int holdCycles = 6;
	localparam int drainCycles = 3;
	// a random load never waits more than one idle cycle, so two cycles per pair at most
	localparam int cycleLimit = resetCycles + resetIdleCycles + 2 * randomCount
		+ cornerCount + backToBackCount + holdCycles + 3 * drainCycles + 50;

	logic clk;
	logic reset;
	logic load;
	operand_t a;
	operand_t b;
	product_t product;
	logic productValid;

	integer seed = 32'h5aae;
	int cycleCount;
	int checkCount;
	int errorCount;
	int testCount;
	int testErrorsBefore;
	int testChecksBefore;

	// expected products in load order, plus the last one that should sit on product
	product_t expectedQueue[$];
	product_t lastProduct;
	// loads of the last two driven cycles, newest in bit 0
	logic [1:0] loadHistory;

	arrayMultiplier i_dut (
		.clk(clk),
		.reset(reset),
		.load(load),
		.a(a),
		.b(b),
		.product(product),
		.productValid(productValid)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	initial begin
		cycleCount = 0;
		while (cycleCount < cycleLimit) begin
			@(posedge clk);
			cycleCount++;
		end
		$display("Timeout: the run went past %0d cycles without finishing", cycleLimit);
		$display("Some tests failed");
		$finish;
	end

	////////////////////////////////////////
	// reference model and checks
	////////////////////////////////////////

	// plain signed multiply, low 32 bits kept
	function automatic product_t multiplyModel(input operand_t x, input operand_t y);
		longint full;
		full = longint'(x) * longint'(y);
		return full[31:0];
	endfunction

	task automatic checkProduct(input product_t actual, input product_t expectedValue);
		checkCount++;
		if (actual !== expectedValue) begin
			errorCount++;
			$display("Error at %0t ns: product is %0d, expected %0d",
				$time, actual, expectedValue);
		end
	endtask

	task automatic checkValid(input logic actual, input logic expectedValue);
		checkCount++;
		if (actual !== expectedValue) begin
			errorCount++;
			$display("Error at %0t ns: productValid is %b, expected %b",
				$time, actual, expectedValue);
		end
	endtask

	////////////////////////////////////////
	// cycle driver
	////////////////////////////////////////

	// outputs settled at the falling edge, so check first and then drive
	task automatic runCycle(input logic doLoad, input operand_t x, input operand_t y);
		logic expectValid;
		@(negedge clk);
		expectValid = loadHistory[1];
		checkValid(productValid, expectValid);
		if (expectValid) begin
			if (expectedQueue.size() == 0) begin
				errorCount++;
				$display("A product was due at %0t ns but no load is waiting for it", $time);
			end else begin
				lastProduct = expectedQueue.pop_front();
			end
		end
		// also covers hold, product keeps the last result while not valid
		checkProduct(product, lastProduct);
		load = doLoad;
		a = x;
		b = y;
		if (doLoad) begin
			expectedQueue.push_back(multiplyModel(x, y));
		end
		loadHistory = {loadHistory[0], doLoad};
	endtask

	task automatic idleCycles(input int count);
		logic [31:0] rnd;
		for (int i = 0; i < count; i++) begin
			rnd = $random(seed);
			runCycle(1'b0, rnd[15:0], rnd[31:16]);
		end
	endtask

	task automatic startTest();
		testErrorsBefore = errorCount;
		testChecksBefore = checkCount;
	endtask

	task automatic finishTest(input string name);
		if (expectedQueue.size() != 0) begin
			errorCount++;
			$display("%s: %0d loaded products never came out", name, expectedQueue.size());
			expectedQueue.delete();
		end
		testCount++;
		$display("%s: %0d checks, %0d errors", name, checkCount - testChecksBefore,
			errorCount - testErrorsBefore);
	endtask

	////////////////////////////////////////
	// tests
	////////////////////////////////////////

	task automatic randomTest();
		logic [31:0] rnd;
		logic lastIdle;
		int loads;
		operand_t x;
		operand_t y;
		loads = 0;
		lastIdle = 1'b0;
		startTest();
		while (loads < randomCount) begin
			rnd = $random(seed);
			x = rnd[15:0];
			y = rnd[31:16];
			rnd = $random(seed);
			// roughly one idle cycle in four, never two in a row
			if (lastIdle || rnd[1:0] != 2'b00) begin
				runCycle(1'b1, x, y);
				loads++;
				lastIdle = 1'b0;
			end else begin
				runCycle(1'b0, x, y);
				lastIdle = 1'b1;
			end
		end
		idleCycles(drainCycles);
		finishTest("random products");
	endtask

	task automatic cornerTest();
		startTest();
		// -32768 * -32768
		runCycle(1'b1, 16'sh8000, 16'sh8000);
		// 32767 * -32768
		runCycle(1'b1, 16'sh7fff, 16'sh8000);
		runCycle(1'b1, 16'sh0000, 16'sh8000);
		runCycle(1'b1, 16'sh3039, 16'sh0000);
		// -1 * -1
		runCycle(1'b1, 16'shffff, 16'shffff);
		// -1 * 32767
		runCycle(1'b1, 16'shffff, 16'sh7fff);
		runCycle(1'b1, 16'sh7fff, 16'sh7fff);
		idleCycles(drainCycles);
		finishTest("corner operands");
	endtask

	task automatic backToBackTest();
		logic [31:0] rnd;
		startTest();
		for (int i = 0; i < backToBackCount; i++) begin
			rnd = $random(seed);
			runCycle(1'b1, rnd[15:0], rnd[31:16]);
		end
		finishTestQuiet();
	endtask

	// the back-to-back results drain out during the hold test
	task automatic finishTestQuiet();
		testCount++;
		$display("back-to-back loads: %0d checks, %0d errors",
			checkCount - testChecksBefore, errorCount - testErrorsBefore);
	endtask

	task automatic holdTest();
		startTest();
		idleCycles(holdCycles);
		finishTest("hold after last load");
	endtask

	initial begin
		reset = 1'b1;
		load = 1'b0;
		a = '0;
		b = '0;
		checkCount = 0;
		errorCount = 0;
		testCount = 0;
		lastProduct = '0;
		loadHistory = 2'b00;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		startTest();
		idleCycles(resetIdleCycles);
		finishTest("reset");

		randomTest();
		cornerTest();
		backToBackTest();
		holdTest();

		$display("%0d tests, %0d checks, %0d errors", testCount, checkCount, errorCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* rtl/arrayMultiplier.sv */
`timescale 1ns/1ns
`default_nettype none

module arrayMultiplier (
	input logic clk,
	input logic reset,
	input logic load,
	input mulPkg::operand_t a,
	input mulPkg::operand_t b,
	output mulPkg::product_t product,
	output logic productValid
);
	import mulPkg::*;

	operand_t opA;
	operand_t opB;
	logic captured;
	logic [operandWidth-1:0] lowBits;
	row_t rowSum;
	row_t rowCarry;
	logic signPair;

	// registered operands
	operandCapture i_capture (
		.clk(clk),
		.reset(reset),
		.load(load),
		.a(a),
		.b(b),
		.opA(opA),
		.opB(opB),
		.captured(captured)
	);

	// combinational partial products and carry-save rows
	baughWooleyArray i_array (
		.opA(opA),
		.opB(opB),
		.lowBits(lowBits),
		.rowSum(rowSum),
		.rowCarry(rowCarry),
		.signPair(signPair)
	);

	// final add and product register
	carrySelectAdder i_adder (
		.clk(clk),
		.reset(reset),
		.captured(captured),
		.lowBits(lowBits),
		.rowSum(rowSum),
		.rowCarry(rowCarry),
		.signPair(signPair),
		.product(product),
		.productValid(productValid)
	);

endmodule

`default_nettype wire

/* rtl/carrySelectAdder.sv */
`timescale 1ns/1ns
`default_nettype none

module carrySelectAdder (
	input logic clk,
	input logic reset,
	input logic captured,
	input logic [mulPkg::operandWidth-1:0] lowBits,
	input mulPkg::row_t rowSum,
	input mulPkg::row_t rowCarry,
	input logic signPair,
	output mulPkg::product_t product,
	output logic productValid
);
	import mulPkg::*;

	// upper addends cover product bits 16 to 30
	row_t upperA;
	row_t upperSum;
	logic [selectBlockWidth:0] rippleCarry;
	logic [selectBlockCount:0] blockCarry;
	logic [productWidth-1:0] fullSum;

	// bit 0 of the last sum row is product bit 15 and already sits in lowBits
	assign upperA = {signPair, rowSum[rowWidth-1:1]};

	////////////////////////////////////////
	// ripple section
	////////////////////////////////////////

	// carry in of one adds the 2^16 half of the sign correction
	assign rippleCarry[0] = 1'b1;

	for (genvar bitIdx = 0; bitIdx < selectBlockWidth; bitIdx++) begin : ripple
		assign upperSum[bitIdx] = upperA[bitIdx] ^ rowCarry[bitIdx] ^ rippleCarry[bitIdx];
		assign rippleCarry[bitIdx+1] = (upperA[bitIdx] & rowCarry[bitIdx])
			| (rippleCarry[bitIdx] & (upperA[bitIdx] ^ rowCarry[bitIdx]));
	end

	assign blockCarry[0] = rippleCarry[selectBlockWidth];

	////////////////////////////////////////
	// carry-select blocks
	////////////////////////////////////////

	// each block is summed for both carries, the incoming carry picks one
	for (genvar blk = 0; blk < selectBlockCount; blk++) begin : selectBlock
		localparam int blockLow = selectBlockWidth * (blk + 1);
		localparam int blockWidth = (blockLow + selectBlockWidth > rowWidth) ?
			rowWidth - blockLow : selectBlockWidth;

		logic [blockWidth:0] sumCarryLow;
		logic [blockWidth:0] sumCarryHigh;

		assign sumCarryLow = {1'b0, upperA[blockLow +: blockWidth]}
			+ {1'b0, rowCarry[blockLow +: blockWidth]};
		assign sumCarryHigh = {1'b0, upperA[blockLow +: blockWidth]}
			+ {1'b0, rowCarry[blockLow +: blockWidth]}
			+ {{blockWidth{1'b0}}, 1'b1};

		assign upperSum[blockLow +: blockWidth] = blockCarry[blk] ?
			sumCarryHigh[blockWidth-1:0] : sumCarryLow[blockWidth-1:0];
		assign blockCarry[blk+1] = blockCarry[blk] ?
			sumCarryHigh[blockWidth] : sumCarryLow[blockWidth];
	end

	// inverting the top carry adds the 2^31 half of the correction
	assign fullSum = {~blockCarry[selectBlockCount], upperSum, lowBits};

	////////////////////////////////////////
	// output register
	////////////////////////////////////////

	// product holds its last value between results
	always_ff @(posedge clk) begin
		if (reset) begin
			product <= '0;
			productValid <= 1'b0;
		end else begin
			productValid <= captured;
			if (captured) begin
				product <= fullSum;
			end
		end
	end

	// ripple and select blocks agree with a plain add of the last row plus the 2^16 one
	selectSumMatches: assert property (
		@(posedge clk) disable iff (reset)
		captured |-> ({blockCarry[selectBlockCount], upperSum}
			== {1'b0, upperA} + {1'b0, rowCarry} + {{rowWidth{1'b0}}, 1'b1})
	);

endmodule

`default_nettype wire

/* rtl/baughWooleyArray.sv */
`timescale 1ns/1ns
`default_nettype none

module baughWooleyArray (
	input mulPkg::operand_t opA,
	input mulPkg::operand_t opB,
	output logic [mulPkg::operandWidth-1:0] lowBits,
	output mulPkg::row_t rowSum,
	output mulPkg::row_t rowCarry,
	output logic signPair
);
	import mulPkg::*;

	// partial[j][i] has weight i + j
	logic [operandWidth-1:0][operandWidth-1:0] partial;

	// carry-save state after each level
	row_t levelSum [rowWidth];
	row_t levelCarry [rowWidth];

	////////////////////////////////////////
	// partial products
	////////////////////////////////////////

	// terms with exactly one sign bit enter inverted, the rest as plain ANDs
	for (genvar j = 0; j < operandWidth; j++) begin : ppRow
		for (genvar i = 0; i < operandWidth; i++) begin : ppBit
			if ((i == operandWidth - 1) != (j == operandWidth - 1)) begin : inverted
				assign partial[j][i] = ~(opA[i] & opB[j]);
			end else begin : plain
				assign partial[j][i] = opA[i] & opB[j];
			end
		end
	end

	// both sign bits together, added at the top of the final row
	assign signPair = partial[operandWidth-1][operandWidth-1];

	////////////////////////////////////////
	// carry-save levels
	////////////////////////////////////////

	// level k folds partial row k+1 into the running sum and carry
	// sum bit t of level k has weight k+1+t, carry bit t has weight k+2+t
	for (genvar k = 0; k < rowWidth; k++) begin : level
		row_t sumIn;
		row_t carryIn;
		row_t addend;

		if (k == 0) begin : first
			// row 0 shifted down by one plays the role of the previous sum
			assign sumIn = partial[0][operandWidth-1:1];
			assign carryIn = '0;
		end else begin : inner
			// the top cell has no sum from above and takes the sign-column term
			assign sumIn = {partial[k][operandWidth-1], levelSum[k-1][rowWidth-1:1]};
			assign carryIn = levelCarry[k-1];
		end

		assign addend = partial[k+1][rowWidth-1:0];

		// one full adder per column, carries ripple down to the next level
		assign levelSum[k] = sumIn ^ addend ^ carryIn;
		assign levelCarry[k] = (sumIn & addend) | (carryIn & (sumIn ^ addend));

		// lowest sum bit of every level is final
		assign lowBits[k+1] = levelSum[k][0];
	end

	assign lowBits[0] = partial[0][0];

	////////////////////////////////////////
	// last row to the final adder
	////////////////////////////////////////

	assign rowSum = levelSum[rowWidth-1];
	assign rowCarry = levelCarry[rowWidth-1];

endmodule

`default_nettype wire

/* rtl/operandCapture.sv */
`timescale 1ns/1ns
`default_nettype none

module operandCapture (
	input logic clk,
	input logic reset,
	input logic load,
	input mulPkg::operand_t a,
	input mulPkg::operand_t b,
	output mulPkg::operand_t opA,
	output mulPkg::operand_t opB,
	output logic captured
);
	import mulPkg::*;

	// operand registers only move on a loading edge
	always_ff @(posedge clk) begin
		if (load) begin
			opA <= a;
			opB <= b;
		end
	end

	// high for the single cycle that follows each loading edge
	always_ff @(posedge clk) begin
		if (reset) begin
			captured <= 1'b0;
		end else begin
			captured <= load;
		end
	end

	////////////////////////////////////////
	// checks
	////////////////////////////////////////

	// the array sees stable operands unless a load was taken
	operandsHeld: assert property (
		@(posedge clk) disable iff (reset)
		!$past(load) |-> ($stable(opA) && $stable(opB))
	);

endmodule

`default_nettype wire

/* rtl/mulPkg.sv */
`default_nettype none

package mulPkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	localparam int operandWidth = 16;
	localparam int productWidth = 2 * operandWidth;

	// one carry-save row is one bit narrower than an operand
	localparam int rowWidth = operandWidth - 1;

	////////////////////////////////////////
	// final adder partitioning
	////////////////////////////////////////

	// the lowest block ripples, the rest are carry-select
	localparam int selectBlockWidth = 4;
	localparam int selectBlockCount = (rowWidth + selectBlockWidth - 1) / selectBlockWidth - 1;

	////////////////////////////////////////
	// types
	////////////////////////////////////////

	typedef logic signed [operandWidth-1:0] operand_t;
	typedef logic signed [productWidth-1:0] product_t;
	typedef logic [rowWidth-1:0] row_t;

endpackage

`default_nettype wire
